/* memIqAgeSelect.sv */
`timescale 1ns/1ns

module memIqAgeSelect (
    input  memIqPkg::iqEntryT                   Entries [memIqPkg::QueueDepth],
    input  logic                                WantLoad,
    output logic                                Found,
    output logic [memIqPkg::EntryIdxWidth-1:0]  Idx
);

    // tree kept as a heap, node n has children 2n+1 and 2n+2
    // leaves sit at QueueDepth-1 .. 2*QueueDepth-2
    logic                                 nodeValid [2*memIqPkg::QueueDepth-1];
    logic [memIqPkg::EntryIdxWidth-1:0]   nodeIdx   [2*memIqPkg::QueueDepth-1];
    logic [memIqPkg::RobPtrWidth-1:0]     nodeRob   [2*memIqPkg::QueueDepth-1];

    always_comb begin
        for (int i = 0; i < memIqPkg::QueueDepth; i++) begin
            nodeValid[memIqPkg::QueueDepth-1+i] = memIqPkg::entryReady(Entries[i])
                && (memIqPkg::isLoadOp(Entries[i].op) == WantLoad);
            nodeIdx[memIqPkg::QueueDepth-1+i]   = memIqPkg::EntryIdxWidth'(i);
            nodeRob[memIqPkg::QueueDepth-1+i]   = Entries[i].robPtr;
        end

        // four levels of pairwise compares, walked bottom up
        for (int n = memIqPkg::QueueDepth - 2; n >= 0; n--) begin
            if (nodeValid[2*n+1] && (!nodeValid[2*n+2]
                    || memIqPkg::isOlder(nodeRob[2*n+1], nodeRob[2*n+2]))) begin
                nodeValid[n] = 1'b1;
                nodeIdx[n]   = nodeIdx[2*n+1];
                nodeRob[n]   = nodeRob[2*n+1];
            end else begin
                nodeValid[n] = nodeValid[2*n+2];  // right wins or nobody
                nodeIdx[n]   = nodeIdx[2*n+2];
                nodeRob[n]   = nodeRob[2*n+2];
            end
        end
    end

    assign Found = nodeValid[0];
    assign Idx   = nodeIdx[0];

endmodule

/* memIqDispatch.sv */
`timescale 1ns/1ns

module memIqDispatch (
    input  memIqPkg::dispatchSlotT                  Dispatch   [memIqPkg::DispatchWidth],
    input  memIqPkg::wakeupT                        Wakeup     [memIqPkg::WakeupPorts],
    input  memIqPkg::iqEntryT                       Entries    [memIqPkg::QueueDepth],
    output logic [memIqPkg::DispatchWidth-1:0]      WriteEn,
    output logic [memIqPkg::EntryIdxWidth-1:0]      WriteIdx   [memIqPkg::DispatchWidth],
    output memIqPkg::iqEntryT                       WriteEntry [memIqPkg::DispatchWidth],
    output logic                                    QueueFull
);

    logic [memIqPkg::QueueDepth-1:0]    freeMask;
    logic [memIqPkg::DispatchWidth-1:0] slotFound;
    logic [memIqPkg::EntryIdxWidth-1:0] slotIdx [memIqPkg::DispatchWidth];

    always_comb begin
        for (int i = 0; i < memIqPkg::QueueDepth; i++) begin
            freeMask[i] = !Entries[i].valid;
        end
    end

    // chained lowest-free search, each slot masks out what the previous one took
    always_comb begin
        logic [memIqPkg::QueueDepth-1:0] remaining;
        remaining = freeMask;
        for (int s = 0; s < memIqPkg::DispatchWidth; s++) begin
            slotFound[s] = 1'b0;
            slotIdx[s]   = '0;
            for (int i = memIqPkg::QueueDepth - 1; i >= 0; i--) begin
                if (remaining[i]) begin  // last hit wins, so lowest index
                    slotFound[s] = 1'b1;
                    slotIdx[s]   = memIqPkg::EntryIdxWidth'(i);
                end
            end
            if (slotFound[s]) begin
                remaining[slotIdx[s]] = 1'b0;
            end
        end
    end

    always_comb begin
        for (int s = 0; s < memIqPkg::DispatchWidth; s++) begin
            WriteEn[s]  = Dispatch[s].valid && slotFound[s];  // no room means dropped
            WriteIdx[s] = slotIdx[s];

            WriteEntry[s].valid      = 1'b1;
            WriteEntry[s].op         = Dispatch[s].op;
            WriteEntry[s].src1.able  = Dispatch[s].src1.able;
            WriteEntry[s].src1.tag   = Dispatch[s].src1.tag;
            WriteEntry[s].src1.ready = Dispatch[s].src1.ready || !Dispatch[s].src1.able
                                       || memIqPkg::srcWoken(Dispatch[s].src1.tag, Wakeup);
            WriteEntry[s].src2.able  = Dispatch[s].src2.able;
            WriteEntry[s].src2.tag   = Dispatch[s].src2.tag;
            WriteEntry[s].src2.ready = Dispatch[s].src2.ready || !Dispatch[s].src2.able
                                       || memIqPkg::srcWoken(Dispatch[s].src2.tag, Wakeup);
            WriteEntry[s].rdAble     = Dispatch[s].rdAble;
            WriteEntry[s].rdTag      = Dispatch[s].rdTag;
            WriteEntry[s].immAble    = Dispatch[s].immAble;
            WriteEntry[s].imm        = Dispatch[s].imm;
            WriteEntry[s].robPtr     = Dispatch[s].robPtr;
        end
    end

    // full when a whole dispatch group would not fit
    assign QueueFull = $countones(freeMask) < memIqPkg::DispatchWidth;

endmodule

/* memIqEntries.sv */
`timescale 1ns/1ns

module memIqEntries (
    input  logic                                    Clk,
    input  logic                                    arstN,
    input  logic                                    MemQStop,
    input  logic                                    MemQFlash,
    input  memIqPkg::wakeupT                        Wakeup     [memIqPkg::WakeupPorts],
    input  logic [memIqPkg::DispatchWidth-1:0]      WriteEn,
    input  logic [memIqPkg::EntryIdxWidth-1:0]      WriteIdx   [memIqPkg::DispatchWidth],
    input  memIqPkg::iqEntryT                       WriteEntry [memIqPkg::DispatchWidth],
    input  logic                                    LoadClear,
    input  logic [memIqPkg::EntryIdxWidth-1:0]      LoadClearIdx,
    input  logic                                    StoreClear,
    input  logic [memIqPkg::EntryIdxWidth-1:0]      StoreClearIdx,
    output memIqPkg::iqEntryT                       Entries    [memIqPkg::QueueDepth]
);

    logic [memIqPkg::QueueDepth-1:0] occupied;
    memIqPkg::iqEntryT               slots [memIqPkg::QueueDepth];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            occupied <= '0;
        end else if (MemQFlash) begin
            occupied <= '0;  // dispatches this cycle are lost too
        end else begin
            for (int s = 0; s < memIqPkg::DispatchWidth; s++) begin
                if (WriteEn[s]) begin
                    occupied[WriteIdx[s]] <= 1'b1;
                end
            end
            // issued entries leave, never the ones just written
            if (LoadClear) begin
                occupied[LoadClearIdx] <= 1'b0;
            end
            if (StoreClear) begin
                occupied[StoreClearIdx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clk) begin
        for (int i = 0; i < memIqPkg::QueueDepth; i++) begin
            if (!MemQStop) begin
                if (slots[i].src1.able && memIqPkg::srcWoken(slots[i].src1.tag, Wakeup)) begin
                    slots[i].src1.ready <= 1'b1;
                end
                if (slots[i].src2.able && memIqPkg::srcWoken(slots[i].src2.tag, Wakeup)) begin
                    slots[i].src2.ready <= 1'b1;
                end
            end
        end
        // a write replaces the whole slot, including its wakeup state
        for (int s = 0; s < memIqPkg::DispatchWidth; s++) begin
            if (WriteEn[s]) begin
                slots[WriteIdx[s]] <= WriteEntry[s];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < memIqPkg::QueueDepth; i++) begin
            Entries[i]       = slots[i];
            Entries[i].valid = occupied[i];
        end
    end

endmodule

/* memIqIssueStage.sv */
`timescale 1ns/1ns

module memIqIssueStage (
    input  logic                                Clk,
    input  logic                                arstN,
    input  logic                                MemQStop,
    input  logic                                MemQFlash,
    input  logic                                LoadReq,
    input  logic                                StoreReq,
    input  memIqPkg::iqEntryT                   Entries [memIqPkg::QueueDepth],
    input  logic                                LoadFound,
    input  logic [memIqPkg::EntryIdxWidth-1:0]  LoadIdx,
    input  logic                                StoreFound,
    input  logic [memIqPkg::EntryIdxWidth-1:0]  StoreIdx,
    output logic                                LoadClear,
    output logic [memIqPkg::EntryIdxWidth-1:0]  LoadClearIdx,
    output logic                                StoreClear,
    output logic [memIqPkg::EntryIdxWidth-1:0]  StoreClearIdx,
    output logic                                LoadValid,
    output memIqPkg::issuedOpT                  LoadOp,
    output logic                                StoreValid,
    output memIqPkg::issuedOpT                  StoreOp
);

    logic loadGrant;
    logic storeGrant;

    function automatic memIqPkg::issuedOpT toIssued(input memIqPkg::iqEntryT e);
        memIqPkg::issuedOpT issued;
        issued.op       = e.op;
        issued.src1Able = e.src1.able;
        issued.src1Tag  = e.src1.tag;
        issued.src2Able = e.src2.able;
        issued.src2Tag  = e.src2.tag;
        issued.rdAble   = e.rdAble;
        issued.rdTag    = e.rdTag;
        issued.immAble  = e.immAble;
        issued.imm      = e.imm;
        issued.robPtr   = e.robPtr;
        return issued;
    endfunction

    assign loadGrant  = LoadFound && LoadReq && !MemQStop;
    assign storeGrant = StoreFound && StoreReq && !MemQStop;

    // granted entries leave the queue at the same edge the output register loads
    assign LoadClear     = loadGrant;
    assign LoadClearIdx  = LoadIdx;
    assign StoreClear    = storeGrant;
    assign StoreClearIdx = StoreIdx;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            LoadValid  <= 1'b0;
            StoreValid <= 1'b0;
        end else begin
            LoadValid  <= loadGrant && !MemQFlash;  // single cycle pulse
            StoreValid <= storeGrant && !MemQFlash;
        end
    end

    always_ff @(posedge Clk) begin
        if (loadGrant) begin
            LoadOp <= toIssued(Entries[LoadIdx]);
        end
        if (storeGrant) begin
            StoreOp <= toIssued(Entries[StoreIdx]);
        end
    end

endmodule

/* memIqPkg.sv */
package memIqPkg;

    localparam int QueueDepth    = 16;
    localparam int EntryIdxWidth = 4;
    localparam int DispatchWidth = 2;
    localparam int WakeupPorts   = 4;
    localparam int RegTagWidth   = 7;
    localparam int ImmWidth      = 26;
    localparam int RobPtrWidth   = 7;  // msb is the wrap bit

    typedef enum logic [2:0] {
        MemOpLoadB,
        MemOpLoadH,
        MemOpLoadW,
        MemOpStoreB,
        MemOpStoreH,
        MemOpStoreW
    } memOpE;

    // able low means the operand is not used
    typedef struct packed {
        logic                   able;
        logic                   ready;
        logic [RegTagWidth-1:0] tag;
    } srcOperandT;

    typedef struct packed {
        logic                   valid;
        memOpE                  op;
        srcOperandT             src1;
        srcOperandT             src2;
        logic                   rdAble;
        logic [RegTagWidth-1:0] rdTag;
        logic                   immAble;
        logic [ImmWidth-1:0]    imm;
        logic [RobPtrWidth-1:0] robPtr;
    } dispatchSlotT;

    typedef struct packed {
        logic                   valid;  // entry occupied
        memOpE                  op;
        srcOperandT             src1;
        srcOperandT             src2;
        logic                   rdAble;
        logic [RegTagWidth-1:0] rdTag;
        logic                   immAble;
        logic [ImmWidth-1:0]    imm;
        logic [RobPtrWidth-1:0] robPtr;
    } iqEntryT;

    typedef struct packed {
        logic                   valid;
        logic [RegTagWidth-1:0] tag;
    } wakeupT;

    typedef struct packed {
        memOpE                  op;
        logic                   src1Able;
        logic [RegTagWidth-1:0] src1Tag;
        logic                   src2Able;
        logic [RegTagWidth-1:0] src2Tag;
        logic                   rdAble;
        logic [RegTagWidth-1:0] rdTag;
        logic                   immAble;
        logic [ImmWidth-1:0]    imm;
        logic [RobPtrWidth-1:0] robPtr;
    } issuedOpT;

    function automatic logic isLoadOp(input memOpE op);
        return op inside {MemOpLoadB, MemOpLoadH, MemOpLoadW};
    endfunction

    function automatic logic srcWoken(input logic [RegTagWidth-1:0] tag,
                                      input wakeupT wk [WakeupPorts]);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < WakeupPorts; p++) begin
            if (wk[p].valid && (wk[p].tag == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // same wrap bit: smaller index is older, otherwise the larger one is
    function automatic logic isOlder(input logic [RobPtrWidth-1:0] a,
                                     input logic [RobPtrWidth-1:0] b);
        if (a[RobPtrWidth-1] == b[RobPtrWidth-1]) begin
            return a[RobPtrWidth-2:0] < b[RobPtrWidth-2:0];
        end
        return a[RobPtrWidth-2:0] > b[RobPtrWidth-2:0];
    endfunction

    function automatic logic entryReady(input iqEntryT e);
        return e.valid && (e.src1.ready || !e.src1.able) && (e.src2.ready || !e.src2.able);
    endfunction

endpackage

/* memIssueQueue.sv */
`timescale 1ns/1ns

module memIssueQueue (
    input  logic                        Clk,
    input  logic                        arstN,
    input  memIqPkg::dispatchSlotT      Dispatch [memIqPkg::DispatchWidth],
    input  memIqPkg::wakeupT            Wakeup   [memIqPkg::WakeupPorts],
    input  logic                        LoadReq,
    input  logic                        StoreReq,
    input  logic                        MemQStop,
    input  logic                        MemQFlash,
    output logic                        QueueFull,
    output logic                        LoadValid,
    output memIqPkg::issuedOpT          LoadOp,
    output logic                        StoreValid,
    output memIqPkg::issuedOpT          StoreOp
);

    memIqPkg::iqEntryT                  entries    [memIqPkg::QueueDepth];
    logic [memIqPkg::DispatchWidth-1:0] writeEn;
    logic [memIqPkg::EntryIdxWidth-1:0] writeIdx   [memIqPkg::DispatchWidth];
    memIqPkg::iqEntryT                  writeEntry [memIqPkg::DispatchWidth];

    logic                               loadFound;
    logic [memIqPkg::EntryIdxWidth-1:0] loadIdx;
    logic                               storeFound;
    logic [memIqPkg::EntryIdxWidth-1:0] storeIdx;

    logic                               loadClear;
    logic [memIqPkg::EntryIdxWidth-1:0] loadClearIdx;
    logic                               storeClear;
    logic [memIqPkg::EntryIdxWidth-1:0] storeClearIdx;

    memIqDispatch dispatchUnit (
        .Dispatch   (Dispatch),
        .Wakeup     (Wakeup),
        .Entries    (entries),
        .WriteEn    (writeEn),
        .WriteIdx   (writeIdx),
        .WriteEntry (writeEntry),
        .QueueFull  (QueueFull)
    );

    memIqEntries entryArray (
        .Clk           (Clk),
        .arstN         (arstN),
        .MemQStop      (MemQStop),
        .MemQFlash     (MemQFlash),
        .Wakeup        (Wakeup),
        .WriteEn       (writeEn),
        .WriteIdx      (writeIdx),
        .WriteEntry    (writeEntry),
        .LoadClear     (loadClear),
        .LoadClearIdx  (loadClearIdx),
        .StoreClear    (storeClear),
        .StoreClearIdx (storeClearIdx),
        .Entries       (entries)
    );

    // one tree per kind
    memIqAgeSelect loadSelect (
        .Entries  (entries),
        .WantLoad (1'b1),
        .Found    (loadFound),
        .Idx      (loadIdx)
    );

    memIqAgeSelect storeSelect (
        .Entries  (entries),
        .WantLoad (1'b0),
        .Found    (storeFound),
        .Idx      (storeIdx)
    );

    memIqIssueStage issueStage (
        .Clk           (Clk),
        .arstN         (arstN),
        .MemQStop      (MemQStop),
        .MemQFlash     (MemQFlash),
        .LoadReq       (LoadReq),
        .StoreReq      (StoreReq),
        .Entries       (entries),
        .LoadFound     (loadFound),
        .LoadIdx       (loadIdx),
        .StoreFound    (storeFound),
        .StoreIdx      (storeIdx),
        .LoadClear     (loadClear),
        .LoadClearIdx  (loadClearIdx),
        .StoreClear    (storeClear),
        .StoreClearIdx (storeClearIdx),
        .LoadValid     (LoadValid),
        .LoadOp        (LoadOp),
        .StoreValid    (StoreValid),
        .StoreOp       (StoreOp)
    );

endmodule

/* memIssueQueueTb.sv */
`timescale 1ns/1ns

module memIssueQueueTb;

    logic                   Clk = 1'b0;
    logic                   arstN;
    memIqPkg::dispatchSlotT Dispatch [memIqPkg::DispatchWidth];
    memIqPkg::wakeupT       Wakeup   [memIqPkg::WakeupPorts];
    logic                   LoadReq;
    logic                   StoreReq;
    logic                   MemQStop;
    logic                   MemQFlash;
    logic                   QueueFull;
    logic                   LoadValid;
    memIqPkg::issuedOpT     LoadOp;
    logic                   StoreValid;
    memIqPkg::issuedOpT     StoreOp;

    memIqPkg::iqEntryT      mq [memIqPkg::QueueDepth];  // reference queue
    logic                   expLoadValid;
    logic                   expStoreValid;
    memIqPkg::issuedOpT     expLoadOp;
    memIqPkg::issuedOpT     expStoreOp;
    logic                   expFull;
    int                     liveCount;
    logic [31:0]            rngState = 32'hd527;
    int                     errors = 0;
    int                     failedTests = 0;
    int                     testErrBase = 0;

    always #20 Clk = ~Clk;

    memIssueQueue memIssueQueue_inst (.*);

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // across a wrap the smaller index is the younger one
    function automatic logic olderRob(input logic [6:0] a, input logic [6:0] b);
        if (a[6] != b[6]) begin
            return a[5:0] > b[5:0];
        end
        return a[5:0] < b[5:0];
    endfunction

    function automatic logic onBus(input logic [memIqPkg::RegTagWidth-1:0] tag);
        logic hit;
        hit = 1'b0;
        foreach (Wakeup[p]) begin
            hit = hit | (Wakeup[p].valid && Wakeup[p].tag == tag);
        end
        return hit;
    endfunction

    function automatic logic canIssue(input memIqPkg::iqEntryT e, input logic wantLoad);
        logic isLoad;
        isLoad = e.op < memIqPkg::MemOpStoreB;  // loads come first in the enum
        return e.valid && isLoad == wantLoad
            && (!e.src1.able || e.src1.ready) && (!e.src2.able || e.src2.ready);
    endfunction

    function automatic int oldestFor(input logic wantLoad);
        int         best;
        logic [3:0] bestIdx;
        best = -1;
        bestIdx = '0;
        for (int i = 0; i < memIqPkg::QueueDepth; i++) begin
            if (canIssue(mq[i], wantLoad)
                    && (best < 0 || olderRob(mq[i].robPtr, mq[bestIdx].robPtr))) begin
                best = i;
                bestIdx = 4'(i);
            end
        end
        return best;
    endfunction

    function automatic memIqPkg::issuedOpT asIssued(input memIqPkg::iqEntryT e);
        memIqPkg::issuedOpT o;
        o.op       = e.op;
        o.src1Able = e.src1.able;
        o.src1Tag  = e.src1.tag;
        o.src2Able = e.src2.able;
        o.src2Tag  = e.src2.tag;
        o.rdAble   = e.rdAble;
        o.rdTag    = e.rdTag;
        o.immAble  = e.immAble;
        o.imm      = e.imm;
        o.robPtr   = e.robPtr;
        return o;
    endfunction

    // queue model stepped once per clock edge
    always @(posedge Clk or negedge arstN) begin
        memIqPkg::iqEntryT nxt [memIqPkg::QueueDepth];
        int ld;
        int st;
        int freeIdx;
        if (!arstN) begin
            for (int i = 0; i < memIqPkg::QueueDepth; i++) begin
                mq[i].valid <= 1'b0;
            end
            expLoadValid  <= 1'b0;
            expStoreValid <= 1'b0;
        end else begin
            nxt = mq;
            ld = (LoadReq && !MemQStop) ? oldestFor(1'b1) : -1;
            st = (StoreReq && !MemQStop) ? oldestFor(1'b0) : -1;
            expLoadValid  <= ld >= 0 && !MemQFlash;
            expStoreValid <= st >= 0 && !MemQFlash;
            if (ld >= 0) begin
                expLoadOp <= asIssued(mq[4'(ld)]);
            end
            if (st >= 0) begin
                expStoreOp <= asIssued(mq[4'(st)]);
            end
            for (int i = 0; i < memIqPkg::QueueDepth; i++) begin
                if (!MemQStop && nxt[i].src1.able && onBus(nxt[i].src1.tag)) begin
                    nxt[i].src1.ready = 1'b1;
                end
                if (!MemQStop && nxt[i].src2.able && onBus(nxt[i].src2.tag)) begin
                    nxt[i].src2.ready = 1'b1;
                end
            end
            foreach (Dispatch[s]) begin
                freeIdx = -1;
                for (int i = memIqPkg::QueueDepth - 1; i >= 0; i--) begin
                    if (!nxt[i].valid) begin
                        freeIdx = i;
                    end
                end
                if (Dispatch[s].valid && freeIdx >= 0) begin
                    nxt[4'(freeIdx)] = memIqPkg::iqEntryT'(Dispatch[s]);
                    nxt[4'(freeIdx)].src1.ready = Dispatch[s].src1.ready
                        || !Dispatch[s].src1.able || onBus(Dispatch[s].src1.tag);
                    nxt[4'(freeIdx)].src2.ready = Dispatch[s].src2.ready
                        || !Dispatch[s].src2.able || onBus(Dispatch[s].src2.tag);
                end
            end
            if (ld >= 0) begin
                nxt[4'(ld)].valid = 1'b0;
            end
            if (st >= 0) begin
                nxt[4'(st)].valid = 1'b0;
            end
            for (int i = 0; i < memIqPkg::QueueDepth; i++) begin
                if (MemQFlash) begin
                    nxt[i].valid = 1'b0;
                end
            end
            mq <= nxt;
        end
    end

    always_comb begin
        liveCount = 0;
        for (int i = 0; i < memIqPkg::QueueDepth; i++) begin
            if (mq[i].valid) begin
                liveCount++;
            end
        end
        expFull = (memIqPkg::QueueDepth - liveCount) < memIqPkg::DispatchWidth;
    end

    task automatic noteMismatch(input string what);
        errors++;
        $display("[FAIL] %0t ns: %s", $time, what);
    endtask

    assert property (@(posedge Clk) disable iff (!arstN) LoadValid == expLoadValid)
        else noteMismatch("LoadValid differs from the reference queue");
    assert property (@(posedge Clk) disable iff (!arstN) LoadValid |-> LoadOp == expLoadOp)
        else noteMismatch("LoadOp fields differ from the expected load");
    assert property (@(posedge Clk) disable iff (!arstN) StoreValid == expStoreValid)
        else noteMismatch("StoreValid differs from the reference queue");
    assert property (@(posedge Clk) disable iff (!arstN) StoreValid |-> StoreOp == expStoreOp)
        else noteMismatch("StoreOp fields differ from the expected store");
    assert property (@(posedge Clk) disable iff (!arstN) QueueFull == expFull)
        else noteMismatch("QueueFull differs from the free entry count");

    function automatic memIqPkg::dispatchSlotT makeOp(input logic load, input logic src1Ready,
            input logic [6:0] src1Tag, input logic [6:0] rob);
        memIqPkg::dispatchSlotT d;
        logic [31:0]            r;
        r = xorshift();
        d.valid   = 1'b1;
        d.op      = memIqPkg::memOpE'((load ? 3'd0 : 3'd3) + 3'(r[1:0] % 2'd3));
        d.src1    = '{able: 1'b1, ready: src1Ready, tag: src1Tag};
        d.src2    = '{able: r[2], ready: 1'b1, tag: r[9:3]};
        d.rdAble  = load;
        d.rdTag   = r[16:10];
        d.immAble = r[17];
        r = xorshift();
        d.imm     = r[25:0];
        d.robPtr  = rob;
        return d;
    endfunction

    // one cycle of dispatch and an optional broadcast on a random bus
    task automatic drive(input memIqPkg::dispatchSlotT s0, input memIqPkg::dispatchSlotT s1,
                         input logic wake, input logic [6:0] tag);
        logic [31:0] r;
        logic [1:0]  port;
        r = xorshift();
        port = r[1:0];
        @(posedge Clk);
        Dispatch[0]  <= s0;
        Dispatch[1]  <= s1;
        Wakeup[port] <= '{valid: wake, tag: tag};
        @(posedge Clk);
        Dispatch[0].valid  <= 1'b0;
        Dispatch[1].valid  <= 1'b0;
        Wakeup[port].valid <= 1'b0;
    endtask

    task automatic setInputs(input logic loadReq, input logic storeReq, input logic stop,
                             input logic flash);
        @(posedge Clk);
        LoadReq   <= loadReq;
        StoreReq  <= storeReq;
        MemQStop  <= stop;
        MemQFlash <= flash;
    endtask

    task automatic waitIssues(input int loads, input int stores, input int limit);
        int seenLoads;
        int seenStores;
        int n;
        seenLoads = 0;
        seenStores = 0;
        for (n = 0; n < limit && (seenLoads < loads || seenStores < stores); n++) begin
            @(negedge Clk);
            seenLoads += int'(LoadValid);
            seenStores += int'(StoreValid);
        end
        if (seenLoads < loads || seenStores < stores) begin
            errors++;
            $display("timeout: saw %0d of %0d loads and %0d of %0d stores in %0d cycles",
                     seenLoads, loads, seenStores, stores, limit);
        end
    endtask

    task automatic finishTest(input string name);
        if (errors == testErrBase) begin
            $display("test %s: passed", name);
        end else begin
            failedTests++;
            $display("test %s: failed with %0d errors", name, errors - testErrBase);
        end
        testErrBase = errors;
    endtask

    initial begin
        logic [31:0] r;
        int          nLoads;
        arstN     = 1'b0;
        LoadReq   = 1'b0;
        StoreReq  = 1'b0;
        MemQStop  = 1'b0;
        MemQFlash = 1'b0;
        foreach (Dispatch[s]) begin
            Dispatch[s] = '0;
        end
        foreach (Wakeup[p]) begin
            Wakeup[p] = '0;
        end
        repeat (2) @(posedge Clk);
        arstN <= 1'b1;

        setInputs(1'b1, 1'b1, 1'b0, 1'b0);
        repeat (10) @(posedge Clk);
        finishTest("1 idle after reset");

        drive(makeOp(1'b1, 1'b1, 7'h01, 7'h05), '0, 1'b0, '0);
        waitIssues(1, 0, 10);
        repeat (4) @(posedge Clk);  // no second issue
        finishTest("2 single ready load");

        drive(makeOp(1'b0, 1'b0, 7'h55, 7'h06), '0, 1'b0, '0);
        drive('0, '0, 1'b1, 7'h54);  // a different tag leaves it waiting
        repeat (6) @(posedge Clk);
        drive('0, '0, 1'b1, 7'h55);
        waitIssues(0, 1, 10);
        drive('0, makeOp(1'b0, 1'b0, 7'h56, 7'h07), 1'b1, 7'h56);  // woken at dispatch
        waitIssues(0, 1, 10);
        finishTest("3 store wakeup");

        setInputs(1'b0, 1'b0, 1'b0, 1'b0);
        drive(makeOp(1'b1, 1'b1, 7'h01, 7'h01), makeOp(1'b1, 1'b1, 7'h01, 7'h7f), 1'b0, '0);
        drive(makeOp(1'b1, 1'b1, 7'h01, 7'h00), makeOp(1'b0, 1'b1, 7'h01, 7'h02), 1'b0, '0);
        drive(makeOp(1'b1, 1'b1, 7'h01, 7'h7e), '0, 1'b0, '0);
        setInputs(1'b1, 1'b1, 1'b0, 1'b0);
        waitIssues(4, 1, 12);
        finishTest("4 age order across wrap");

        setInputs(1'b1, 1'b1, 1'b1, 1'b0);
        drive(makeOp(1'b1, 1'b1, 7'h02, 7'h08), makeOp(1'b0, 1'b0, 7'h60, 7'h09), 1'b0, '0);
        drive('0, '0, 1'b1, 7'h60);  // lost while stopped
        repeat (6) @(posedge Clk);
        setInputs(1'b0, 1'b1, 1'b0, 1'b0);
        repeat (6) @(posedge Clk);
        setInputs(1'b0, 1'b0, 1'b0, 1'b1);
        setInputs(1'b1, 1'b1, 1'b0, 1'b0);
        repeat (20) @(posedge Clk);
        finishTest("5 stop, back-pressure and flush");

        setInputs(1'b0, 1'b0, 1'b0, 1'b0);
        nLoads = 0;
        for (int k = 0; k < 8; k++) begin
            r = xorshift();
            drive(makeOp(r[0], 1'b0, 7'h10 + 7'(2 * k), 7'(2 * k)),
                  makeOp(r[1], 1'b0, 7'h11 + 7'(2 * k), 7'(2 * k + 1)), 1'b0, '0);
            nLoads += int'(r[0]) + int'(r[1]);
        end
        for (int k = 0; k < 16; k++) begin
            drive('0, '0, 1'b1, 7'h10 + 7'(k));
        end
        setInputs(1'b1, 1'b1, 1'b0, 1'b0);
        waitIssues(nLoads, 16 - nLoads, 40);
        finishTest("6 full queue and drain");

        $display("tests run 6, tests failed %0d, errors %0d", failedTests, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* project.f */
memIqPkg.sv
memIqDispatch.sv
memIqEntries.sv
memIqAgeSelect.sv
memIqIssueStage.sv
memIssueQueue.sv
memIssueQueueTb.sv

/* run.sh */
#!/bin/sh
# builds and runs the memory issue queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module memIssueQueueTb -o simv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/simv)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if printf '%s\n' "$simOut" | grep -qx 'PASS: all tests'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
